// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Test failures found

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
lsu_pkg.sv
mux_key.sv
lsu_store.sv
lsu_load.sv
lsu_ctrl.sv
lsu_data_ram.sv
lsu.sv
tb_lsu.sv

// ==== lsu.sv ====
// Load/store unit top

`timescale 1ns/1ps
`default_nettype none

module lsu import lsu_pkg::*; #(
  parameter int SRAM_ADDR_WD = 8
) (
  input  logic                                i_clk,
  input  logic                                i_arst_n,
  input  logic                                i_req,
  input  logic                                i_we,
  input  logic [MEM_OP_WD-1:0]                i_mem_op,
  input  logic [SRAM_ADDR_WD+BYTE_OFS_WD-1:0] i_addr,
  input  logic [GPR_WD-1:0]                   i_wdata,
  output logic                                o_access_fault,
  output logic                                o_rvalid,
  output logic [GPR_WD-1:0]                   o_rdata
);

  logic                     ram_ce;
  logic                     ram_we;
  logic [SRAM_ADDR_WD-1:0]  ram_addr;
  logic [SRAM_WMASK_WD-1:0] ram_wmask;
  logic [SRAM_DATA_WD-1:0]  ram_wdata;
  logic [SRAM_DATA_WD-1:0]  ram_rdata;
  logic [MEM_OP_WD-1:0]     ld_op;
  logic [BYTE_OFS_WD-1:0]   ld_ofs;

  lsu_ctrl #(.SRAM_ADDR_WD(SRAM_ADDR_WD)) u_ctrl (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_req         (i_req),
    .i_we          (i_we),
    .i_mem_op      (i_mem_op),
    .i_addr        (i_addr),
    .o_access_fault(o_access_fault),
    .o_ram_ce      (ram_ce),
    .o_ram_we      (ram_we),
    .o_ram_addr    (ram_addr),
    .o_ld_op       (ld_op),
    .o_ld_ofs      (ld_ofs),
    .o_rvalid      (o_rvalid)
  );

  lsu_store u_store (
    .i_mem_op(i_mem_op),
    .i_waddr (i_addr[BYTE_OFS_WD-1:0]),
    .i_wdata (i_wdata),
    .o_wmask (ram_wmask),
    .o_wdata (ram_wdata)
  );

  lsu_data_ram #(.SRAM_ADDR_WD(SRAM_ADDR_WD)) u_ram (
    .i_clk  (i_clk),
    .i_ce   (ram_ce),
    .i_we   (ram_we),
    .i_addr (ram_addr),
    .i_wmask(ram_wmask),
    .i_wdata(ram_wdata),
    .o_rdata(ram_rdata)
  );

  // load path works on the op and offset held from the request cycle.
  lsu_load u_load (
    .i_mem_op(ld_op),
    .i_raddr (ld_ofs),
    .i_rword (ram_rdata),
    .o_rdata (o_rdata)
  );

endmodule

`default_nettype wire

// ==== lsu_ctrl.sv ====
// LSU request control

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl import lsu_pkg::*; #(
  parameter int SRAM_ADDR_WD = 8
) (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_req,
  input  logic                            i_we,
  input  logic [MEM_OP_WD-1:0]            i_mem_op,
  input  logic [SRAM_ADDR_WD+BYTE_OFS_WD-1:0] i_addr,
  output logic                            o_access_fault,
  output logic                            o_ram_ce,
  output logic                            o_ram_we,
  output logic [SRAM_ADDR_WD-1:0]         o_ram_addr,
  output logic [MEM_OP_WD-1:0]            o_ld_op,
  output logic [BYTE_OFS_WD-1:0]          o_ld_ofs,
  output logic                            o_rvalid
);

  logic [BYTE_OFS_WD-1:0] ofs;
  logic [1:0]             op_size;
  logic                   misalign;
  logic                   legal;

  assign ofs     = i_addr[BYTE_OFS_WD-1:0];
  assign op_size = i_mem_op[MEM_OP_SIZE_HI:MEM_OP_SIZE_LO];

  // low offset bits below the size must be clear.
  always_comb begin
    misalign = 1'b0;
    case (op_size)
      SIZE_B:  misalign = 1'b0;
      SIZE_H:  misalign = ofs[0];
      SIZE_W:  misalign = |ofs[1:0];
      SIZE_D:  misalign = |ofs;
      default: misalign = 1'b0;
    endcase
  end

  assign o_access_fault = i_req & (misalign | (i_mem_op == MEM_OP_ILL));
  assign legal          = i_req & ~o_access_fault;

  assign o_ram_ce   = legal;
  assign o_ram_we   = legal & i_we;
  assign o_ram_addr = i_addr[SRAM_ADDR_WD+BYTE_OFS_WD-1:BYTE_OFS_WD];

  // ####################################################################
  // load in flight.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= legal & ~i_we;
    end
  end

  always_ff @(posedge i_clk) begin
    if (legal && !i_we) begin
      o_ld_op  <= i_mem_op;
      o_ld_ofs <= ofs;
    end
  end

  // stores, illegal ops and offsets not a multiple of the size return no data.
  a_no_rvalid_after_bad: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_req && (i_we || (i_mem_op == MEM_OP_ILL) ||
      ((int'(ofs) & ((1 << op_size) - 1)) != 0))) |=> !o_rvalid)
    else $error("rvalid after store or faulting request");

endmodule

`default_nettype wire

// ==== lsu_data_ram.sv ====
// LSU data RAM

`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram import lsu_pkg::*; #(
  parameter int SRAM_ADDR_WD = 8
) (
  input  logic                     i_clk,
  input  logic                     i_ce,
  input  logic                     i_we,
  input  logic [SRAM_ADDR_WD-1:0]  i_addr,
  input  logic [SRAM_WMASK_WD-1:0] i_wmask,
  input  logic [SRAM_DATA_WD-1:0]  i_wdata,
  output logic [SRAM_DATA_WD-1:0]  o_rdata
);

  localparam int DEPTH   = 1 << SRAM_ADDR_WD;
  localparam int LANE_WD = SRAM_DATA_WD / SRAM_WMASK_WD;

  logic [SRAM_DATA_WD-1:0] mem [DEPTH];

  // ####################################################################
  // single port, write or read per cycle.
  always_ff @(posedge i_clk) begin
    if (i_ce) begin
      if (i_we) begin
        for (int b = 0; b < SRAM_WMASK_WD; b++) begin
          if (i_wmask[b]) begin
            mem[i_addr][b*LANE_WD +: LANE_WD] <= i_wdata[b*LANE_WD +: LANE_WD];
          end
        end
      end else begin
        // read word held until the next read.
        o_rdata <= mem[i_addr];
      end
    end
  end

  // a legal store always carries at least one byte.
  a_wmask_nonzero: assert property (@(posedge i_clk)
    i_we |-> (i_wmask != '0))
    else $error("store with empty byte mask");

endmodule

`default_nettype wire

// ==== lsu_load.sv ====
// LSU load extraction

`timescale 1ns/1ps
`default_nettype none

module lsu_load import lsu_pkg::*; (
  input  logic [MEM_OP_WD-1:0]    i_mem_op,
  input  logic [BYTE_OFS_WD-1:0]  i_raddr,
  input  logic [SRAM_DATA_WD-1:0] i_rword,
  output logic [GPR_WD-1:0]       o_rdata
);

  logic [SRAM_DATA_WD-1:0] shifted;

  // ####################################################################
  // bring the addressed byte down to lane 0.
  mux_key #(
    .NR_KEY  (8),
    .KEY_LEN (BYTE_OFS_WD),
    .DATA_LEN(SRAM_DATA_WD)
  ) u_shift (
    .i_key(i_raddr),
    .i_lut({
      3'h0, i_rword,
      3'h1, {8'h0,  i_rword[63:8]},
      3'h2, {16'h0, i_rword[63:16]},
      3'h3, {24'h0, i_rword[63:24]},
      3'h4, {32'h0, i_rword[63:32]},
      3'h5, {40'h0, i_rword[63:40]},
      3'h6, {48'h0, i_rword[63:48]},
      3'h7, {56'h0, i_rword[63:56]}
    }),
    .o_out(shifted)
  );

  // ####################################################################
  // size and sign extension per op.
  // illegal op has no entry and reads as zero.
  mux_key #(
    .NR_KEY  (7),
    .KEY_LEN (MEM_OP_WD),
    .DATA_LEN(GPR_WD)
  ) u_extend (
    .i_key(i_mem_op),
    .i_lut({
      MEM_OP_B,  {{56{shifted[7]}},  shifted[7:0]},
      MEM_OP_BU, {56'h0,             shifted[7:0]},
      MEM_OP_H,  {{48{shifted[15]}}, shifted[15:0]},
      MEM_OP_HU, {48'h0,             shifted[15:0]},
      MEM_OP_W,  {{32{shifted[31]}}, shifted[31:0]},
      MEM_OP_WU, {32'h0,             shifted[31:0]},
      MEM_OP_D,  shifted
    }),
    .o_out(o_rdata)
  );

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
// LSU shared definitions

`default_nettype none

package lsu_pkg;

  // ####################################################################
  // data path widths.
  localparam int GPR_WD        = 64;
  localparam int SRAM_DATA_WD  = 64;
  localparam int SRAM_WMASK_WD = 8;
  localparam int BYTE_OFS_WD   = 3;
  localparam int MEM_OP_WD     = 3;

  // ####################################################################
  // memory op codes, bit 0 set means unsigned load.
  localparam logic [MEM_OP_WD-1:0] MEM_OP_B   = 3'b000;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_BU  = 3'b001;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_H   = 3'b010;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_HU  = 3'b011;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_W   = 3'b100;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_WU  = 3'b101;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_D   = 3'b110;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_ILL = 3'b111;

  // size field inside the op.
  localparam int MEM_OP_SIZE_HI = 2;
  localparam int MEM_OP_SIZE_LO = 1;
  localparam logic [1:0] SIZE_B = 2'b00;
  localparam logic [1:0] SIZE_H = 2'b01;
  localparam logic [1:0] SIZE_W = 2'b10;
  localparam logic [1:0] SIZE_D = 2'b11;

endpackage

`default_nettype wire

// ==== lsu_store.sv ====
// LSU store alignment

`timescale 1ns/1ps
`default_nettype none

module lsu_store import lsu_pkg::*; (
  input  logic [MEM_OP_WD-1:0]     i_mem_op,
  input  logic [BYTE_OFS_WD-1:0]   i_waddr,
  input  logic [GPR_WD-1:0]        i_wdata,
  output logic [SRAM_WMASK_WD-1:0] o_wmask,
  output logic [SRAM_DATA_WD-1:0]  o_wdata
);

  // ####################################################################
  // byte mask, zero when the offset does not fit the size.
  always_comb begin
    o_wmask = '0;
    case (i_mem_op)
      MEM_OP_B, MEM_OP_BU: begin
        o_wmask = 8'b0000_0001 << i_waddr;
      end
      MEM_OP_H, MEM_OP_HU: begin
        if (i_waddr[0] == 1'b0) o_wmask = 8'b0000_0011 << i_waddr;
      end
      MEM_OP_W, MEM_OP_WU: begin
        if (i_waddr[1:0] == 2'b00) o_wmask = 8'b0000_1111 << i_waddr;
      end
      MEM_OP_D: begin
        if (i_waddr == 3'h0) o_wmask = 8'b1111_1111;
      end
      default: o_wmask = '0;
    endcase
  end

  // ####################################################################
  // move the store value up to its byte lane.
  mux_key #(
    .NR_KEY  (8),
    .KEY_LEN (BYTE_OFS_WD),
    .DATA_LEN(SRAM_DATA_WD)
  ) u_shift (
    .i_key(i_waddr),
    .i_lut({
      3'h0, i_wdata,
      3'h1, {i_wdata[55:0], 8'h0},
      3'h2, {i_wdata[47:0], 16'h0},
      3'h3, {i_wdata[39:0], 24'h0},
      3'h4, {i_wdata[31:0], 32'h0},
      3'h5, {i_wdata[23:0], 40'h0},
      3'h6, {i_wdata[15:0], 48'h0},
      3'h7, {i_wdata[7:0],  56'h0}
    }),
    .o_out(o_wdata)
  );

endmodule

`default_nettype wire

// ==== mux_key.sv ====
// Keyed lookup multiplexer

`timescale 1ns/1ps
`default_nettype none

module mux_key #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                   i_key,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] i_lut,
  output logic [DATA_LEN-1:0]                  o_out
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  // each pair is {key, data}, pairs packed back to back.
  // no match gives zero.
  always_comb begin
    o_out = '0;
    for (int i = 0; i < NR_KEY; i++) begin
      if (i_lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == i_key) begin
        o_out = i_lut[i*PAIR_LEN +: DATA_LEN];
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_lsu.sv ====
// LSU directed testbench

`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

  localparam int SRAM_ADDR_WD = 8;
  localparam int ADDR_WD      = SRAM_ADDR_WD + BYTE_OFS_WD;
  localparam int CLK_PERIOD   = 20;
  localparam int TEST_CYCLES  = 750;
  localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 4;

  logic                 clk;
  logic                 arst_n;
  logic                 req;
  logic                 we;
  logic [MEM_OP_WD-1:0] mem_op;
  logic [ADDR_WD-1:0]   addr;
  logic [GPR_WD-1:0]    wdata;
  logic                 access_fault;
  logic                 rvalid;
  logic [GPR_WD-1:0]    rdata;

  // byte-wide little-endian reference memory.
  logic [7:0]           ref_mem [1 << ADDR_WD];
  logic                 pend_valid;
  logic [GPR_WD-1:0]    pend_data;
  int                   checks;
  int                   errors;
  int                   tests;
  integer               seed;

  lsu #(.SRAM_ADDR_WD(SRAM_ADDR_WD)) dut_i (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_req         (req),
    .i_we          (we),
    .i_mem_op      (mem_op),
    .i_addr        (addr),
    .i_wdata       (wdata),
    .o_access_fault(access_fault),
    .o_rvalid      (rvalid),
    .o_rdata       (rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ####################################################################
  // reference model.
  function automatic int size_bytes(input logic [MEM_OP_WD-1:0] op);
    return 1 << op[MEM_OP_SIZE_HI:MEM_OP_SIZE_LO];
  endfunction

  function automatic logic faults(input logic [MEM_OP_WD-1:0] op,
                                  input logic [ADDR_WD-1:0] a);
    return (op == MEM_OP_ILL) || ((int'(a) % size_bytes(op)) != 0);
  endfunction

  function automatic logic [ADDR_WD-1:0] addr_of(input logic [SRAM_ADDR_WD-1:0] word,
                                                 input logic [BYTE_OFS_WD-1:0] ofs);
    return {word, ofs};
  endfunction

  function automatic logic [GPR_WD-1:0] model_load(input logic [MEM_OP_WD-1:0] op,
                                                   input logic [ADDR_WD-1:0] a);
    logic [GPR_WD-1:0] val;
    int                n;
    n = size_bytes(op);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[8*i +: 8] = ref_mem[int'(a) + i];
    end
    // signed ops copy the top loaded bit upward.
    if (!op[0]) begin
      for (int j = 8 * n; j < GPR_WD; j++) begin
        val[j] = val[8*n-1];
      end
    end
    return val;
  endfunction

  task automatic model_store(input logic [MEM_OP_WD-1:0] op, input logic [ADDR_WD-1:0] a,
                             input logic [GPR_WD-1:0] d);
    for (int i = 0; i < size_bytes(op); i++) begin
      ref_mem[int'(a) + i] = d[8*i +: 8];
    end
  endtask

  // ####################################################################
  // drive and check helpers.
  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // checks the load of the cycle before, then drives one request.
  task automatic step(input logic r, input logic w, input logic [MEM_OP_WD-1:0] op,
                      input logic [ADDR_WD-1:0] a, input logic [GPR_WD-1:0] d);
    logic exp_fault;
    @(posedge clk);
    #2;
    check_value("o_rvalid", 64'(rvalid), 64'(pend_valid));
    if (pend_valid && rvalid) begin
      check_value("o_rdata", rdata, pend_data);
    end
    req = r;
    we = w;
    mem_op = op;
    addr = a;
    wdata = d;
    #1;
    exp_fault = r && faults(op, a);
    check_value("o_access_fault", 64'(access_fault), 64'(exp_fault));
    pend_valid = r && !exp_fault && !w;
    if (pend_valid) begin
      pend_data = model_load(op, a);
    end
    if (r && !exp_fault && w) begin
      model_store(op, a, d);
    end
  endtask

  task automatic store(input logic [MEM_OP_WD-1:0] op, input logic [ADDR_WD-1:0] a,
                       input logic [GPR_WD-1:0] d);
    step(1'b1, 1'b1, op, a, d);
  endtask

  task automatic load(input logic [MEM_OP_WD-1:0] op, input logic [ADDR_WD-1:0] a);
    step(1'b1, 1'b0, op, a, '0);
  endtask

  task automatic idle();
    step(1'b0, 1'b0, MEM_OP_B, '0, '0);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("[%0t ns] %s finished, %0d errors", $time, name, errors - errs_before);
  endtask

  // ####################################################################
  // tests.
  task automatic reset_and_double();
    int e0;
    e0 = errors;
    check_value("o_rvalid", 64'(rvalid), 64'h0);
    store(MEM_OP_D, addr_of(8'd3, 3'd0), 64'h0123_4567_89ab_cdef);
    load(MEM_OP_D, addr_of(8'd3, 3'd0));
    idle();
    end_test("reset_double", e0);
  endtask

  task automatic byte_lane_merge();
    int e0;
    e0 = errors;
    store(MEM_OP_D, addr_of(8'd5, 3'd0), 64'hffff_ffff_ffff_ffff);
    store(MEM_OP_D, addr_of(8'd6, 3'd0), 64'h5a5a_a5a5_3c3c_c3c3);
    // partial merge checked after every byte.
    for (int i = 0; i < 8; i++) begin
      store(MEM_OP_B, addr_of(8'd5, 3'(i)), {56'hbad0_bad0_bad0_ba, 8'(17 * (i + 1))});
      load(MEM_OP_D, addr_of(8'd5, 3'd0));
    end
    load(MEM_OP_D, addr_of(8'd6, 3'd0));
    idle();
    end_test("byte_lanes", e0);
  endtask

  task automatic load_extension();
    int e0;
    e0 = errors;
    // mixed sign bits in bytes, halves and words.
    store(MEM_OP_D, addr_of(8'd9, 3'd0), 64'h70f1_7f02_c3d4_15e6);
    for (int o = 0; o < 7; o++) begin
      for (int ofs = 0; ofs < 8; ofs += size_bytes(3'(o))) begin
        load(3'(o), addr_of(8'd9, 3'(ofs)));
      end
    end
    idle();
    end_test("load_extend", e0);
  endtask

  task automatic access_faults();
    int e0;
    e0 = errors;
    store(MEM_OP_D, addr_of(8'd12, 3'd0), 64'h1111_2222_3333_4444);
    store(MEM_OP_H, addr_of(8'd12, 3'd1), 64'hdead_beef_dead_beef);
    store(MEM_OP_W, addr_of(8'd12, 3'd2), 64'hdead_beef_dead_beef);
    store(MEM_OP_D, addr_of(8'd12, 3'd4), 64'hdead_beef_dead_beef);
    store(MEM_OP_ILL, addr_of(8'd12, 3'd0), 64'hdead_beef_dead_beef);
    load(MEM_OP_HU, addr_of(8'd12, 3'd3));
    load(MEM_OP_W, addr_of(8'd12, 3'd6));
    load(MEM_OP_D, addr_of(8'd12, 3'd1));
    load(MEM_OP_ILL, addr_of(8'd12, 3'd0));
    load(MEM_OP_D, addr_of(8'd12, 3'd0));
    idle();
    end_test("faults", e0);
  endtask

  task automatic random_traffic();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    // random traffic stays inside 16 words written here first.
    for (int w = 0; w < 16; w++) begin
      store(MEM_OP_D, addr_of(8'(w), 3'd0), {$random(seed), $random(seed)});
    end
    for (int k = 0; k < 300; k++) begin
      r = $random(seed);
      step(1'b1, r[0], r[3:1], addr_of({4'h0, r[7:4]}, r[10:8]),
           {$random(seed), $random(seed)});
    end
    idle();
    end_test("random", e0);
  endtask

  // ####################################################################
  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    mem_op = MEM_OP_B;
    addr = '0;
    wdata = '0;
    pend_valid = 1'b0;
    pend_data = '0;
    checks = 0;
    errors = 0;
    tests = 0;
    seed = 32'h7502_996a;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    reset_and_double();
    byte_lane_merge();
    load_extension();
    access_faults();
    random_traffic();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
